//--- imem.hex
// one 32-bit instruction word per line, word index 0 first
00ff5a13
01fe5b13
02fd5813
03fc5913
04fb5e13
05fa5f13
06f95c13
07f85d13
08f75213
09f65313
0af55013
0bf45113
0cf35613
0df25713
0ef15413
0ff05513
10ef4a13
11ee4b13
12ed4813
13ec4913
14eb4e13
15ea4f13
16e94c13
17e84d13
18e74213
19e64313
1ae54013
1be44113
1ce34613
1de24713
1ee14413
1fe04513
20df7a13
21de7b13
22dd7813
23dc7913
24db7e13
25da7f13
26d97c13
27d87d13
28d77213
29d67313
2ad57013
2bd47113
2cd37613
2dd27713
2ed17413
2fd07513
30cf6a13
31ce6b13
32cd6813
33cc6913
34cb6e13
35ca6f13
36c96c13
37c86d13
38c76213
39c66313
3ac56013
3bc46113
3cc36613
3dc26713
3ec16413
3fc06513

//--- vlog.f
+incdir+.
fetch_pkg.sv
noicache_fetch.sv
fetch_biu_arbiter.sv
imem_rom.sv
fetch_subsystem.sv
tb_fetch_subsystem.sv

//--- run_sim.sh
#!/bin/sh
# compile with verilator and run, pass only if the pass line is printed
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f vlog.f \
  --top-module tb_fetch_subsystem -o sim_fetch &&
./obj_dir/sim_fetch | tee /dev/stderr | grep -x "TEST PASS" > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

//--- tb_fetch_subsystem.sv
// fetch subsystem testbench with clock, reset, hart pc drivers, reference model, checks and watchdog

`include "fetch_settings.svh"

module tb_fetch_subsystem
  import fetch_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  // parcel counts per test size the watchdog
  localparam int TEST_LEN_SUM    = 20 + 40 + 16 + 16 + 12 + 8;
  localparam int WATCHDOG_CYCLES = TEST_LEN_SUM * 20;
  localparam int NH              = `NUM_HARTS;

  logic                             clk;
  logic                             rstn;
  logic [`NUM_HARTS-1:0][`PLEN-1:0] nxt_pc;
  logic [`NUM_HARTS-1:0]            stall;
  logic [`NUM_HARTS-1:0]            flush;
  logic [`NUM_HARTS-1:0]            flush_rdy;
  logic [`NUM_HARTS-1:0]            stall_nxt_pc;
  logic [`NUM_HARTS-1:0][`XLEN-1:0] parcel_pc;
  logic [`NUM_HARTS-1:0][`XLEN-1:0] parcel;
  logic [`NUM_HARTS-1:0]            parcel_valid;
  logic [`NUM_HARTS-1:0]            parcel_misaligned;

  // reference rom contents
  logic [`XLEN-1:0] model [`IMEM_DEPTH];

  // accepted pcs still waiting for their parcel
  logic [`PLEN-1:0] exp_q [NH][$];

  // per-hart driver state
  logic [`PLEN-1:0] cur_pc    [NH];
  bit               accepted  [NH];
  bit               flush_dly [NH];
  int               rcv_cnt   [NH];
  bit               run       [NH];
  int               stall_pct [NH];
  bit               rdy       [NH];
  bit               flush_req [NH];
  bit               rst_req;
  bit               rst_dly;

  string test_name;
  int    err_cnt;
  int    mis_seen;
  int    pass_tests;
  int    fail_tests;
  int    test_base;

  fetch_subsystem fetch_subsystem_inst (
    .clk               (clk),
    .rstn              (rstn),
    .nxt_pc            (nxt_pc),
    .stall             (stall),
    .flush             (flush),
    .flush_rdy         (flush_rdy),
    .stall_nxt_pc      (stall_nxt_pc),
    .parcel_pc         (parcel_pc),
    .parcel            (parcel),
    .parcel_valid      (parcel_valid),
    .parcel_misaligned (parcel_misaligned)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // reporting
  //////////////////////////////////////////////////////////////////////

  task automatic note_value(input string what, input logic [31:0] e, input logic [31:0] a);
    $display("error %s: %s expected %h actual %h", test_name, what, e, a);
    err_cnt++;
  endtask

  task automatic note_other(input string msg);
    $display("error %s: %s", test_name, msg);
    err_cnt++;
  endtask

  // compare one parcel beat with the oldest accepted pc
  task automatic check_parcel(input int h);
    logic [`PLEN-1:0] pc;
    logic [`XLEN-1:0] word;
    word_index_t      idx;
    assert (exp_q[h].size() != 0) else begin
      note_other($sformatf("hart %0d presented a parcel with no fetch outstanding", h));
    end
    if (exp_q[h].size() != 0) begin
      pc   = exp_q[h].pop_front();
      // word index from address bits above bit 1 wraps at rom depth
      idx  = word_index_t'(pc[`PLEN-1:2] % `IMEM_DEPTH);
      word = model[idx];
      assert (parcel_pc[h] == pc) else note_value("parcel_pc", pc, parcel_pc[h]);
      assert (parcel[h] == word) else note_value("parcel", word, parcel[h]);
      assert (parcel_misaligned[h] == (pc[1:0] != 2'b00)) else begin
        note_value("parcel_misaligned", pc[1:0] != 2'b00, parcel_misaligned[h]);
      end
      rcv_cnt[h]++;
      if (parcel_misaligned[h]) begin
        mis_seen++;
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // monitor samples mid-cycle where everything is settled
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    for (int h = 0; h < NH; h++) begin
      if (!rstn || rst_dly) begin
        assert (!parcel_valid[h]) else note_other($sformatf("hart %0d parcel in reset", h));
      end
      if (flush[h] || flush_dly[h]) begin
        assert (!parcel_valid[h]) else note_other($sformatf("hart %0d parcel near flush", h));
      end
      if (!flush_rdy[h]) begin
        assert (stall_nxt_pc[h]) else note_other($sformatf("hart %0d took pc, not ready", h));
        assert (!parcel_valid[h]) else note_other($sformatf("hart %0d parcel, not ready", h));
      end
      if (parcel_valid[h]) begin
        check_parcel(h);
      end
      // pc taken this cycle
      accepted[h] = rstn && !stall_nxt_pc[h];
      if (accepted[h]) begin
        exp_q[h].push_back(nxt_pc[h]);
      end
      if (flush[h] || !rstn) begin
        exp_q[h].delete();
      end
      flush_dly[h] = flush[h];
    end
    rst_dly = !rstn;
  end

  //////////////////////////////////////////////////////////////////////
  // hart drivers
  //////////////////////////////////////////////////////////////////////

  // one cycle for all harts with inputs changed just after the edge
  task automatic step_cycle();
    @(posedge clk);
    #1;
    rstn = !rst_req;
    for (int h = 0; h < NH; h++) begin
      if (accepted[h]) begin
        cur_pc[h] = nxt_pc[h] + 4;
      end
      nxt_pc[h]    = cur_pc[h];
      stall[h]     = !run[h] || (($urandom % 100) < stall_pct[h]);
      flush[h]     = flush_req[h];
      flush_rdy[h] = rdy[h];
    end
  endtask

  // keep stepping until every selected hart got n more parcels
  task automatic run_parcels(input int mask, input int n);
    int  base [NH];
    bit  done;
    for (int h = 0; h < NH; h++) begin
      base[h] = rcv_cnt[h];
    end
    done = 1'b0;
    while (!done) begin
      step_cycle();
      done = 1'b1;
      for (int h = 0; h < NH; h++) begin
        if (mask[h] && (rcv_cnt[h] - base[h] < n)) begin
          done = 1'b0;
        end
      end
    end
  endtask

  // single flush cycle on the selected harts
  task automatic flush_pulse(input int mask);
    for (int h = 0; h < NH; h++) begin
      flush_req[h] = mask[h];
    end
    step_cycle();
    for (int h = 0; h < NH; h++) begin
      flush_req[h] = 1'b0;
    end
  endtask

  task automatic start_hart(input int h, input logic [`PLEN-1:0] pc, input int pct);
    cur_pc[h]    = pc;
    stall_pct[h] = pct;
    run[h]       = 1'b1;
  endtask

  // flush and park the selected harts between tests
  task automatic park_harts(input int mask);
    flush_pulse(mask);
    for (int h = 0; h < NH; h++) begin
      if (mask[h]) begin
        run[h] = 1'b0;
      end
    end
    step_cycle();
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_base = err_cnt;
    mis_seen  = 0;
  endtask

  task automatic end_test();
    if (err_cnt == test_base) begin
      $display("test %s: pass", test_name);
      pass_tests++;
    end else begin
      $display("test %s: fail, %0d errors", test_name, err_cnt - test_base);
      fail_tests++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(11));
    $readmemh("imem.hex", model);
    rstn      = 1'b0;
    nxt_pc    = '0;
    stall     = '1;
    flush     = '0;
    flush_rdy = '1;
    rst_req   = 1'b1;
    rst_dly   = 1'b1;
    test_name = "startup";
    for (int h = 0; h < NH; h++) begin
      cur_pc[h]    = '0;
      accepted[h]  = 1'b0;
      flush_dly[h] = 1'b0;
      rcv_cnt[h]   = 0;
      run[h]       = 1'b0;
      stall_pct[h] = 0;
      rdy[h]       = 1'b1;
      flush_req[h] = 1'b0;
    end
    repeat (2) step_cycle();
    rst_req = 1'b0;
    step_cycle();

    begin_test("single_hart");
    start_hart(0, 32'h0, 0);
    run_parcels(1, 20);
    park_harts(1);
    end_test();

    // distinct start addresses so a misrouted reply shows up
    begin_test("all_harts_random_stall");
    for (int h = 0; h < NH; h++) begin
      start_hart(h, 32'(h * 'h44), 25);
    end
    run_parcels(4'hf, 40);
    park_harts(4'hf);
    end_test();

    begin_test("flush_restart");
    start_hart(3, 32'h80, 0);
    run_parcels(8, 8);
    flush_pulse(8);
    cur_pc[3] = 32'h20;
    run_parcels(8, 8);
    park_harts(8);
    end_test();

    begin_test("flush_rdy_low");
    start_hart(2, 32'h10, 0);
    run_parcels(4, 8);
    rdy[2] = 1'b0;
    repeat (8) step_cycle();
    rdy[2] = 1'b1;
    run_parcels(4, 8);
    park_harts(4);
    end_test();

    begin_test("misaligned");
    start_hart(1, 32'h06, 0);
    run_parcels(2, 6);
    assert (mis_seen > 0) else note_other("misaligned pc never flagged");
    flush_pulse(2);
    cur_pc[1] = 32'h30;
    run_parcels(2, 6);
    park_harts(2);
    end_test();

    // reset in the middle of traffic
    begin_test("reset_midrun");
    for (int h = 0; h < NH; h++) begin
      start_hart(h, 32'(h * 'h20 + 'h8), 0);
    end
    run_parcels(4'hf, 4);
    rst_req = 1'b1;
    repeat (3) step_cycle();
    rst_req = 1'b0;
    run_parcels(4'hf, 4);
    park_harts(4'hf);
    end_test();

    $display("tests passed %0d failed %0d", pass_tests, fail_tests);
    if (fail_tests == 0 && err_cnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired in %s before the tests finished", test_name);
    $display("TEST FAIL");
    $finish;
  end

endmodule

//--- fetch_subsystem.sv
// fetch subsystem top: per-hart fetch units, shared arbiter and instruction rom

`include "fetch_settings.svh"

module fetch_subsystem
  import fetch_pkg::*;
(
  input  logic                              clk,
  input  logic                              rstn,
  input  logic [`NUM_HARTS-1:0][`PLEN-1:0]  nxt_pc,
  input  logic [`NUM_HARTS-1:0]             stall,
  input  logic [`NUM_HARTS-1:0]             flush,
  input  logic [`NUM_HARTS-1:0]             flush_rdy,
  output logic [`NUM_HARTS-1:0]             stall_nxt_pc,
  output logic [`NUM_HARTS-1:0][`XLEN-1:0]  parcel_pc,
  output logic [`NUM_HARTS-1:0][`XLEN-1:0]  parcel,
  output logic [`NUM_HARTS-1:0]             parcel_valid,
  output logic [`NUM_HARTS-1:0]             parcel_misaligned
);

  //////////////////////////////////////////////////////////////////////
  // fetch unit to arbiter
  //////////////////////////////////////////////////////////////////////

  logic [`NUM_HARTS-1:0]            biu_stb;
  logic [`NUM_HARTS-1:0]            biu_stb_ack;
  logic [`NUM_HARTS-1:0][`PLEN-1:0] biu_adri;
  logic [`NUM_HARTS-1:0]            biu_ack;
  logic [`XLEN-1:0]                 biu_do;
  logic [`PLEN-1:0]                 biu_adro;

  // arbiter to rom
  logic                             mem_req;
  logic [`PLEN-1:0]                 mem_adr;
  logic                             mem_ack;
  logic [`XLEN-1:0]                 mem_dat;
  logic [`PLEN-1:0]                 mem_adr_out;

  for (genvar h = 0; h < `NUM_HARTS; h++) begin : g_hart
    // slot index, same encoding the arbiter uses for owners
    localparam hart_id_t HART = hart_id_t'(h);

    noicache_fetch fetch_inst (
      .clk               (clk),
      .rstn              (rstn),
      .nxt_pc            (nxt_pc[HART]),
      .stall             (stall[HART]),
      .flush             (flush[HART]),
      .flush_rdy         (flush_rdy[HART]),
      .stall_nxt_pc      (stall_nxt_pc[HART]),
      .parcel_pc         (parcel_pc[HART]),
      .parcel            (parcel[HART]),
      .parcel_valid      (parcel_valid[HART]),
      .parcel_misaligned (parcel_misaligned[HART]),
      .biu_stb           (biu_stb[HART]),
      .biu_stb_ack       (biu_stb_ack[HART]),
      .biu_adri          (biu_adri[HART]),
      .biu_do            (biu_do),
      .biu_adro          (biu_adro),
      .biu_ack           (biu_ack[HART])
    );
  end

  fetch_biu_arbiter arbiter_inst (
    .clk         (clk),
    .rstn        (rstn),
    .biu_stb     (biu_stb),
    .biu_adri    (biu_adri),
    .biu_stb_ack (biu_stb_ack),
    .biu_ack     (biu_ack),
    .biu_do      (biu_do),
    .biu_adro    (biu_adro),
    .mem_req     (mem_req),
    .mem_adr     (mem_adr),
    .mem_ack     (mem_ack),
    .mem_dat     (mem_dat),
    .mem_adr_out (mem_adr_out)
  );

  imem_rom rom_inst (
    .clk         (clk),
    .rstn        (rstn),
    .mem_req     (mem_req),
    .mem_adr     (mem_adr),
    .mem_ack     (mem_ack),
    .mem_dat     (mem_dat),
    .mem_adr_out (mem_adr_out)
  );

endmodule

//--- imem_rom.sv
// pipelined instruction rom with fixed read latency, contents from imem.hex

`include "fetch_settings.svh"

module imem_rom
  import fetch_pkg::*;
(
  input  logic              clk,
  input  logic              rstn,
  input  logic              mem_req,
  input  logic [`PLEN-1:0]  mem_adr,
  output logic              mem_ack,
  output logic [`XLEN-1:0]  mem_dat,
  output logic [`PLEN-1:0]  mem_adr_out
);

  logic [`XLEN-1:0] mem [`IMEM_DEPTH];

  // one stage per latency cycle
  logic             req_q [`IMEM_LATENCY];
  logic [`PLEN-1:0] adr_q [`IMEM_LATENCY];
  logic [`XLEN-1:0] dat_q [`IMEM_LATENCY];
  word_index_t      rd_idx;

  initial begin
    $readmemh("imem.hex", mem);
  end

  // word address, wraps at rom depth
  assign rd_idx = word_index_t'(mem_adr >> 2);

  // request flags only, they gate the ack
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      for (int i = 0; i < `IMEM_LATENCY; i++) begin
        req_q[i] <= 1'b0;
      end
    end else begin
      req_q[0] <= mem_req;
      for (int i = 1; i < `IMEM_LATENCY; i++) begin
        req_q[i] <= req_q[i-1];
      end
    end
  end

  // array read in the first stage, then carried along
  always_ff @(posedge clk) begin
    adr_q[0] <= mem_adr;
    dat_q[0] <= mem[rd_idx];
    for (int i = 1; i < `IMEM_LATENCY; i++) begin
      adr_q[i] <= adr_q[i-1];
      dat_q[i] <= dat_q[i-1];
    end
  end

  assign mem_ack     = req_q[`IMEM_LATENCY-1];
  assign mem_adr_out = adr_q[`IMEM_LATENCY-1];
  assign mem_dat     = dat_q[`IMEM_LATENCY-1];

endmodule

//--- fetch_biu_arbiter.sv
// round-robin fetch request arbiter with owner pipeline for reply steering

`include "fetch_settings.svh"

module fetch_biu_arbiter
  import fetch_pkg::*;
(
  input  logic                              clk,
  input  logic                              rstn,

  // fetch unit requests
  input  logic [`NUM_HARTS-1:0]             biu_stb,
  input  logic [`NUM_HARTS-1:0][`PLEN-1:0]  biu_adri,
  output logic [`NUM_HARTS-1:0]             biu_stb_ack,

  // replies, data and address broadcast
  output logic [`NUM_HARTS-1:0]             biu_ack,
  output logic [`XLEN-1:0]                  biu_do,
  output logic [`PLEN-1:0]                  biu_adro,

  // instruction bus
  output logic                              mem_req,
  output logic [`PLEN-1:0]                  mem_adr,
  input  logic                              mem_ack,
  input  logic [`XLEN-1:0]                  mem_dat,
  input  logic [`PLEN-1:0]                  mem_adr_out
);

  hart_id_t last_q;
  hart_id_t gnt_id;
  logic     gnt_valid;

  // owner of each access in flight, last stage lines up with mem_ack
  hart_id_t owner_q [`IMEM_LATENCY];

  //////////////////////////////////////////////////////////////////////
  // grant
  //////////////////////////////////////////////////////////////////////

  // search starts one past the previous winner
  always_comb begin
    int unsigned idx;
    gnt_valid = 1'b0;
    gnt_id    = last_q;
    for (int i = 1; i <= `NUM_HARTS; i++) begin
      idx = (int'(last_q) + i) % `NUM_HARTS;
      if (!gnt_valid && biu_stb[idx]) begin
        gnt_valid = 1'b1;
        gnt_id    = hart_id_t'(idx);
      end
    end
  end

  always_comb begin
    biu_stb_ack = '0;
    if (gnt_valid) begin
      biu_stb_ack[gnt_id] = 1'b1;
    end
  end

  // rom never stalls, so a grant is a bus access
  assign mem_req = gnt_valid;
  assign mem_adr = biu_adri[gnt_id];

  // hart 0 gets first pick out of reset
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      last_q <= hart_id_t'(`NUM_HARTS - 1);
    end else if (gnt_valid) begin
      last_q <= gnt_id;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // reply steering
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    owner_q[0] <= gnt_id;
    for (int i = 1; i < `IMEM_LATENCY; i++) begin
      owner_q[i] <= owner_q[i-1];
    end
  end

  always_comb begin
    biu_ack = '0;
    if (mem_ack) begin
      biu_ack[owner_q[`IMEM_LATENCY-1]] = 1'b1;
    end
  end

  assign biu_do   = mem_dat;
  assign biu_adro = mem_adr_out;

endmodule

//--- noicache_fetch.sv
// per-hart fetch unit: next-pc strobe, outstanding counter, flush masking, three entry return queue

`include "fetch_settings.svh"

module noicache_fetch
  import fetch_pkg::*;
(
  input  logic              clk,
  input  logic              rstn,

  // hart side
  input  logic [`PLEN-1:0]  nxt_pc,
  input  logic              stall,
  input  logic              flush,
  input  logic              flush_rdy,
  output logic              stall_nxt_pc,
  output logic [`XLEN-1:0]  parcel_pc,
  output logic [`XLEN-1:0]  parcel,
  output logic              parcel_valid,
  output logic              parcel_misaligned,

  // toward the arbiter
  output logic              biu_stb,
  input  logic              biu_stb_ack,
  output logic [`PLEN-1:0]  biu_adri,
  input  logic [`XLEN-1:0]  biu_do,
  input  logic [`PLEN-1:0]  biu_adro,
  input  logic              biu_ack
);

  //////////////////////////////////////////////////////////////////////
  // state
  //////////////////////////////////////////////////////////////////////

  logic [1:0]       stb_cnt;
  logic             flush_dly;
  fifo_fill_t       fill_q;
  fifo_fill_t       fill_inc;
  fifo_fill_t       fill_dec;
  logic             q_full1;
  logic             ret_we;
  logic             ret_rd;
  logic [1:0]       wr_idx;

  // return queue payload, entry 0 is the head
  logic [`XLEN-1:0] q_dat [3];
  logic [`PLEN-1:0] q_adr [3];

  // entry 1 occupied, no room for another in-flight pair
  assign q_full1 = (fill_q == FILL_TWO) || (fill_q == FILL_THREE);

  //////////////////////////////////////////////////////////////////////
  // hart and bus side
  //////////////////////////////////////////////////////////////////////

  // request goes out combinationally from the hart's next pc
  assign biu_stb  = flush_rdy & ~flush & ~stall & ~q_full1;
  assign biu_adri = nxt_pc;

  // hart must hold its pc until a strobe is taken
  assign stall_nxt_pc = ~flush_rdy | ~biu_stb_ack | q_full1;

  // head entry presented, masked in flush cycle and the one after
  assign parcel_valid = flush_rdy & ~(flush | flush_dly) & ~stall & (fill_q != FILL_EMPTY);
  assign parcel_pc    = q_adr[0];
  assign parcel       = q_dat[0];

  // no 16-bit support, just flag it
  assign parcel_misaligned = |q_adr[0][1:0];

  // delayed flush for parcel masking
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      flush_dly <= 1'b0;
    end else begin
      flush_dly <= flush;
    end
  end

  // outstanding counter, shifts a one in per accepted strobe
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      stb_cnt <= 2'b00;
    end else if (flush) begin
      stb_cnt <= 2'b00;
    end else if (biu_stb_ack) begin
      stb_cnt <= {1'b1, stb_cnt[1]};
    end
  end

  //////////////////////////////////////////////////////////////////////
  // return queue
  //////////////////////////////////////////////////////////////////////

  // stale replies after a flush find the counter clear and are dropped
  assign ret_we = biu_ack & (|stb_cnt) & ~flush;
  assign ret_rd = parcel_valid;

  // fill up and down, saturating at both ends
  always_comb begin
    fill_inc = fill_q;
    fill_dec = fill_q;
    case (fill_q)
      FILL_EMPTY: fill_inc = FILL_ONE;
      FILL_ONE: begin
        fill_inc = FILL_TWO;
        fill_dec = FILL_EMPTY;
      end
      FILL_TWO: begin
        fill_inc = FILL_THREE;
        fill_dec = FILL_ONE;
      end
      FILL_THREE: fill_dec = FILL_TWO;
      default: ;
    endcase
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      fill_q <= FILL_EMPTY;
    end else if (flush) begin
      fill_q <= FILL_EMPTY;
    end else begin
      case ({ret_we, ret_rd})
        2'b10:   fill_q <= fill_inc;
        2'b01:   fill_q <= fill_dec;
        // read and write together keep the fill
        default: fill_q <= fill_q;
      endcase
    end
  end

  // append slot, one lower when the head pops in the same cycle
  always_comb begin
    wr_idx = fill_q;
    if (ret_rd) begin
      wr_idx = fill_q - 2'd1;
    end else if (fill_q == FILL_THREE) begin
      wr_idx = 2'd2;
    end
  end

  // shift on read, then append; the later write wins on the same slot
  always_ff @(posedge clk) begin
    if (ret_rd) begin
      q_dat[0] <= q_dat[1];
      q_adr[0] <= q_adr[1];
      q_dat[1] <= q_dat[2];
      q_adr[1] <= q_adr[2];
    end
    if (ret_we) begin
      q_dat[wr_idx] <= biu_do;
      q_adr[wr_idx] <= biu_adro;
    end
  end

endmodule

//--- fetch_pkg.sv
// fetch subsystem package: hart index type, rom word index type, fetch queue fill enum

`include "fetch_settings.svh"

package fetch_pkg;

  //////////////////////////////////////////////////////////////////////
  // index types
  //////////////////////////////////////////////////////////////////////

  // selects one hart, used for arbitration and reply steering
  typedef logic [$clog2(`NUM_HARTS)-1:0] hart_id_t;

  // word address into the instruction rom
  typedef logic [$clog2(`IMEM_DEPTH)-1:0] word_index_t;

  //////////////////////////////////////////////////////////////////////
  // fetch queue occupancy
  //////////////////////////////////////////////////////////////////////

  // number of valid entries in the three deep return queue
  // entry 0 is always the head
  typedef enum logic [1:0] {
    FILL_EMPTY = 2'd0,
    FILL_ONE   = 2'd1,
    FILL_TWO   = 2'd2,
    FILL_THREE = 2'd3
  } fifo_fill_t;

endpackage

//--- fetch_settings.svh
// global fetch subsystem macros: data and address widths, hart count, ROM size and latency

`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

//////////////////////////////////////////////////////////////////////
// datapath widths
//////////////////////////////////////////////////////////////////////

// instruction word and parcel width
`define XLEN 32

// physical address width
`define PLEN 32

//////////////////////////////////////////////////////////////////////
// cluster and memory sizing
//////////////////////////////////////////////////////////////////////

// one fetch unit per hart
`define NUM_HARTS 4

// rom words, power of two so the index wraps cleanly
`define IMEM_DEPTH 64

// cycles from accepted strobe to ack, must be at least 1
`define IMEM_LATENCY 2

`endif
